//--- common/frame_consts.svh
`ifndef FRAME_CONSTS_SVH
`define FRAME_CONSTS_SVH

// visible image size in pixels
`define FRAME_WIDTH 640
`define FRAME_HEIGHT 480

// two pixels are packed into each memory word
`define ROW_WORDS 320

// one full image, FRAME_HEIGHT rows of ROW_WORDS words
`define SLOT_WORDS 153600

// external bank geometry
`define PIXEL_BITS 36
`define ADDR_BITS 19

// coordinate widths
`define X_BITS 10
`define Y_BITS 9

`endif

//--- common/frame_mem_pkg.sv
`include "frame_consts.svh"

package frame_mem_pkg;

	// one word of an external bank
	typedef logic [`PIXEL_BITS-1:0] pixel_t;
	typedef logic [`ADDR_BITS-1:0] addr_t;

	typedef logic [`X_BITS-1:0] x_t;
	typedef logic [`Y_BITS-1:0] y_t;

	// image position inside a bank, only 0 to 2 are real slots
	typedef logic [1:0] loc_t;

	typedef struct packed {
		logic bank;
		loc_t loc;
	} slot_t;

	// grant tag on a bank and tag of a read in flight
	typedef enum logic [2:0] {
		CLIENT_NONE,
		CLIENT_CAPTURE,
		CLIENT_DISPLAY,
		CLIENT_FILTER,
		CLIENT_FETCH
	} client_t;

endpackage

//--- verilog/frame_rotator.sv
`timescale 1ns/1ps

module frame_rotator (
	input logic clk,
	input logic reset,
	input logic frame_flag,
	output frame_mem_pkg::slot_t capture_slot,
	output frame_mem_pkg::slot_t filter_slot,
	output frame_mem_pkg::slot_t fetch_slot,
	output frame_mem_pkg::slot_t display_slot
);

	always_ff @(posedge clk) begin
		if (reset) begin
			capture_slot.bank <= 1'b0;
			capture_slot.loc <= 2'd0;
			filter_slot.bank <= 1'b0;
			filter_slot.loc <= 2'd1;
			fetch_slot.bank <= 1'b1;
			fetch_slot.loc <= 2'd0;
			display_slot.bank <= 1'b1;
			display_slot.loc <= 2'd1;
		end else if (frame_flag) begin
			// the captured image moves on to be fetched, the fetched one is shown,
			// the shown slot is handed to filter and the filtered slot is refilled
			capture_slot <= filter_slot;
			filter_slot <= display_slot;
			fetch_slot <= capture_slot;
			display_slot <= fetch_slot;
		end
	end

endmodule

//--- arbiter/pixel_address.sv
`timescale 1ns/1ps
`include "frame_consts.svh"

module pixel_address (
	input frame_mem_pkg::x_t x,
	input frame_mem_pkg::y_t y,
	input frame_mem_pkg::loc_t loc,
	output frame_mem_pkg::addr_t addr
);

	frame_mem_pkg::addr_t row_base;
	frame_mem_pkg::addr_t slot_base;

	assign row_base = frame_mem_pkg::addr_t'(y * `ROW_WORDS);

	always_comb begin
		case (loc)
			2'd1: slot_base = frame_mem_pkg::addr_t'(`SLOT_WORDS);
			2'd2: slot_base = frame_mem_pkg::addr_t'(2 * `SLOT_WORDS);
			// loc 3 has no slot behind it and falls back to slot 0
			default: slot_base = '0;
		endcase
	end

	// x drops its low bit, both pixels of a pair share one word
	assign addr = frame_mem_pkg::addr_t'(x[`X_BITS-1:1]) + row_base + slot_base;

endmodule

//--- arbiter/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter #(
	parameter bit BANK = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic capture_flag,
	input logic display_flag,
	input logic filter_flag,
	input logic fetch_flag,
	input logic capture_bank,
	input logic display_bank,
	input logic filter_bank,
	input logic fetch_bank,
	input frame_mem_pkg::addr_t capture_addr,
	input frame_mem_pkg::addr_t display_addr,
	input frame_mem_pkg::addr_t filter_addr,
	input frame_mem_pkg::addr_t fetch_addr,
	input frame_mem_pkg::pixel_t capture_pixel,
	input frame_mem_pkg::pixel_t filter_pixel_write,
	input frame_mem_pkg::pixel_t fetch_pixel_write,
	input logic filter_wr,
	input logic fetch_wr,
	output frame_mem_pkg::addr_t mem_addr,
	output frame_mem_pkg::pixel_t mem_write,
	output logic mem_wr,
	output frame_mem_pkg::client_t grant,
	output logic grant_wr
);

	frame_mem_pkg::client_t sel;
	logic sel_wr;

	// fixed priority, capture first so the camera never stalls
	always_comb begin
		if (capture_flag && capture_bank == BANK)
			sel = frame_mem_pkg::CLIENT_CAPTURE;
		else if (display_flag && display_bank == BANK)
			sel = frame_mem_pkg::CLIENT_DISPLAY;
		else if (filter_flag && filter_bank == BANK)
			sel = frame_mem_pkg::CLIENT_FILTER;
		else if (fetch_flag && fetch_bank == BANK)
			sel = frame_mem_pkg::CLIENT_FETCH;
		else
			sel = frame_mem_pkg::CLIENT_NONE;
	end

	always_comb begin
		case (sel)
			frame_mem_pkg::CLIENT_CAPTURE: sel_wr = 1'b1;
			frame_mem_pkg::CLIENT_FILTER: sel_wr = filter_wr;
			frame_mem_pkg::CLIENT_FETCH: sel_wr = fetch_wr;
			default: sel_wr = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			grant <= frame_mem_pkg::CLIENT_NONE;
			mem_wr <= 1'b0;
		end else begin
			grant <= sel;
			mem_wr <= sel_wr;
		end
	end

	always_ff @(posedge clk) begin
		case (sel)
			frame_mem_pkg::CLIENT_CAPTURE: begin
				mem_addr <= capture_addr;
				mem_write <= capture_pixel;
			end
			// display only reads, write data is left as it was
			frame_mem_pkg::CLIENT_DISPLAY: begin
				mem_addr <= display_addr;
			end
			frame_mem_pkg::CLIENT_FILTER: begin
				mem_addr <= filter_addr;
				mem_write <= filter_pixel_write;
			end
			frame_mem_pkg::CLIENT_FETCH: begin
				mem_addr <= fetch_addr;
				mem_write <= fetch_pixel_write;
			end
			default: begin
				mem_addr <= '0;
				mem_write <= '0;
			end
		endcase
	end

	// write bit of the registered grant, kept with the tag for the read pipe
	assign grant_wr = mem_wr;

endmodule

//--- verilog/read_return.sv
`timescale 1ns/1ps

module read_return (
	input logic clk,
	input logic reset,
	input frame_mem_pkg::client_t grant0,
	input frame_mem_pkg::client_t grant1,
	input logic grant0_wr,
	input logic grant1_wr,
	input frame_mem_pkg::pixel_t mem0_read,
	input frame_mem_pkg::pixel_t mem1_read,
	output frame_mem_pkg::pixel_t display_pixel,
	output frame_mem_pkg::pixel_t filter_pixel_read,
	output frame_mem_pkg::pixel_t fetch_pixel_read
);

	frame_mem_pkg::client_t read0_tag;
	frame_mem_pkg::client_t read1_tag;
	frame_mem_pkg::client_t tag0_q1;
	frame_mem_pkg::client_t tag0_q2;
	frame_mem_pkg::client_t tag1_q1;
	frame_mem_pkg::client_t tag1_q2;

	// writes return nothing, so they enter the pipe as empty slots
	assign read0_tag = grant0_wr ? frame_mem_pkg::CLIENT_NONE : grant0;
	assign read1_tag = grant1_wr ? frame_mem_pkg::CLIENT_NONE : grant1;

	// word for a client if one of the banks returns it now, else the held value
	function automatic frame_mem_pkg::pixel_t route(
		input frame_mem_pkg::client_t who,
		input frame_mem_pkg::client_t bank0_tag,
		input frame_mem_pkg::client_t bank1_tag,
		input frame_mem_pkg::pixel_t bank0_word,
		input frame_mem_pkg::pixel_t bank1_word,
		input frame_mem_pkg::pixel_t held
	);
		if (bank0_tag == who)
			return bank0_word;
		if (bank1_tag == who)
			return bank1_word;
		return held;
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			tag0_q1 <= frame_mem_pkg::CLIENT_NONE;
			tag0_q2 <= frame_mem_pkg::CLIENT_NONE;
			tag1_q1 <= frame_mem_pkg::CLIENT_NONE;
			tag1_q2 <= frame_mem_pkg::CLIENT_NONE;
			display_pixel <= '0;
			filter_pixel_read <= '0;
			fetch_pixel_read <= '0;
		end else begin
			// matches the two cycle read latency of the banks
			tag0_q1 <= read0_tag;
			tag0_q2 <= tag0_q1;
			tag1_q1 <= read1_tag;
			tag1_q2 <= tag1_q1;
			display_pixel <= route(frame_mem_pkg::CLIENT_DISPLAY, tag0_q2, tag1_q2,
				mem0_read, mem1_read, display_pixel);
			filter_pixel_read <= route(frame_mem_pkg::CLIENT_FILTER, tag0_q2, tag1_q2,
				mem0_read, mem1_read, filter_pixel_read);
			fetch_pixel_read <= route(frame_mem_pkg::CLIENT_FETCH, tag0_q2, tag1_q2,
				mem0_read, mem1_read, fetch_pixel_read);
		end
	end

endmodule

//--- verilog/frame_mem_interface.sv
`timescale 1ns/1ps

module frame_mem_interface (
	input logic clk,
	input logic reset,
	input logic frame_flag,
	input logic capture_flag,
	input frame_mem_pkg::x_t capture_x,
	input frame_mem_pkg::y_t capture_y,
	input frame_mem_pkg::pixel_t capture_pixel,
	output logic done_capture,
	input logic display_flag,
	input frame_mem_pkg::x_t display_x,
	input frame_mem_pkg::y_t display_y,
	output logic done_display,
	output frame_mem_pkg::pixel_t display_pixel,
	input logic filter_flag,
	input logic filter_wr,
	input frame_mem_pkg::x_t filter_x,
	input frame_mem_pkg::y_t filter_y,
	input frame_mem_pkg::pixel_t filter_pixel_write,
	output logic done_filter,
	output frame_mem_pkg::pixel_t filter_pixel_read,
	input logic fetch_flag,
	input logic fetch_wr,
	input frame_mem_pkg::x_t fetch_x,
	input frame_mem_pkg::y_t fetch_y,
	input frame_mem_pkg::pixel_t fetch_pixel_write,
	output logic done_fetch,
	output frame_mem_pkg::pixel_t fetch_pixel_read,
	output frame_mem_pkg::addr_t mem0_addr,
	output frame_mem_pkg::pixel_t mem0_write,
	output logic mem0_wr,
	input frame_mem_pkg::pixel_t mem0_read,
	output frame_mem_pkg::addr_t mem1_addr,
	output frame_mem_pkg::pixel_t mem1_write,
	output logic mem1_wr,
	input frame_mem_pkg::pixel_t mem1_read
);

	frame_mem_pkg::slot_t capture_slot;
	frame_mem_pkg::slot_t filter_slot;
	frame_mem_pkg::slot_t fetch_slot;
	frame_mem_pkg::slot_t display_slot;

	frame_mem_pkg::addr_t capture_addr;
	frame_mem_pkg::addr_t display_addr;
	frame_mem_pkg::addr_t filter_addr;
	frame_mem_pkg::addr_t fetch_addr;

	frame_mem_pkg::client_t grant0;
	frame_mem_pkg::client_t grant1;
	logic grant0_wr;
	logic grant1_wr;

	frame_rotator rotator (
		.clk(clk),
		.reset(reset),
		.frame_flag(frame_flag),
		.capture_slot(capture_slot),
		.filter_slot(filter_slot),
		.fetch_slot(fetch_slot),
		.display_slot(display_slot)
	);

	// word address of each client inside its own image slot
	pixel_address capture_address (
		.x(capture_x), .y(capture_y), .loc(capture_slot.loc), .addr(capture_addr)
	);
	pixel_address display_address (
		.x(display_x), .y(display_y), .loc(display_slot.loc), .addr(display_addr)
	);
	pixel_address filter_address (
		.x(filter_x), .y(filter_y), .loc(filter_slot.loc), .addr(filter_addr)
	);
	pixel_address fetch_address (
		.x(fetch_x), .y(fetch_y), .loc(fetch_slot.loc), .addr(fetch_addr)
	);

	bank_arbiter #(.BANK(1'b0)) bank0_arbiter (
		.clk(clk),
		.reset(reset),
		.capture_flag(capture_flag),
		.display_flag(display_flag),
		.filter_flag(filter_flag),
		.fetch_flag(fetch_flag),
		.capture_bank(capture_slot.bank),
		.display_bank(display_slot.bank),
		.filter_bank(filter_slot.bank),
		.fetch_bank(fetch_slot.bank),
		.capture_addr(capture_addr),
		.display_addr(display_addr),
		.filter_addr(filter_addr),
		.fetch_addr(fetch_addr),
		.capture_pixel(capture_pixel),
		.filter_pixel_write(filter_pixel_write),
		.fetch_pixel_write(fetch_pixel_write),
		.filter_wr(filter_wr),
		.fetch_wr(fetch_wr),
		.mem_addr(mem0_addr),
		.mem_write(mem0_write),
		.mem_wr(mem0_wr),
		.grant(grant0),
		.grant_wr(grant0_wr)
	);

	bank_arbiter #(.BANK(1'b1)) bank1_arbiter (
		.clk(clk),
		.reset(reset),
		.capture_flag(capture_flag),
		.display_flag(display_flag),
		.filter_flag(filter_flag),
		.fetch_flag(fetch_flag),
		.capture_bank(capture_slot.bank),
		.display_bank(display_slot.bank),
		.filter_bank(filter_slot.bank),
		.fetch_bank(fetch_slot.bank),
		.capture_addr(capture_addr),
		.display_addr(display_addr),
		.filter_addr(filter_addr),
		.fetch_addr(fetch_addr),
		.capture_pixel(capture_pixel),
		.filter_pixel_write(filter_pixel_write),
		.fetch_pixel_write(fetch_pixel_write),
		.filter_wr(filter_wr),
		.fetch_wr(fetch_wr),
		.mem_addr(mem1_addr),
		.mem_write(mem1_write),
		.mem_wr(mem1_wr),
		.grant(grant1),
		.grant_wr(grant1_wr)
	);

	read_return returns (
		.clk(clk),
		.reset(reset),
		.grant0(grant0),
		.grant1(grant1),
		.grant0_wr(grant0_wr),
		.grant1_wr(grant1_wr),
		.mem0_read(mem0_read),
		.mem1_read(mem1_read),
		.display_pixel(display_pixel),
		.filter_pixel_read(filter_pixel_read),
		.fetch_pixel_read(fetch_pixel_read)
	);

	// done in the same cycle the command is on the bank
	assign done_capture = grant0 == frame_mem_pkg::CLIENT_CAPTURE ||
		grant1 == frame_mem_pkg::CLIENT_CAPTURE;
	assign done_display = grant0 == frame_mem_pkg::CLIENT_DISPLAY ||
		grant1 == frame_mem_pkg::CLIENT_DISPLAY;
	assign done_filter = grant0 == frame_mem_pkg::CLIENT_FILTER ||
		grant1 == frame_mem_pkg::CLIENT_FILTER;
	assign done_fetch = grant0 == frame_mem_pkg::CLIENT_FETCH ||
		grant1 == frame_mem_pkg::CLIENT_FETCH;

endmodule

//--- tests/tb_frame_mem.sv
`timescale 1ns/1ps
`include "frame_consts.svh"

module tb_frame_mem;

	localparam int CYCLE_LIMIT = 3000;

	// role order along which a slot travels on each frame strobe
	localparam int POS_CAPTURE = 0;
	localparam int POS_FETCH = 1;
	localparam int POS_DISPLAY = 2;
	localparam int POS_FILTER = 3;

	logic clk;
	logic reset;
	logic frame_flag;
	logic capture_flag, display_flag, filter_flag, fetch_flag;
	logic filter_wr, fetch_wr;
	logic done_capture, done_display, done_filter, done_fetch;
	frame_mem_pkg::x_t capture_x, display_x, filter_x, fetch_x;
	frame_mem_pkg::y_t capture_y, display_y, filter_y, fetch_y;
	frame_mem_pkg::pixel_t capture_pixel, filter_pixel_write, fetch_pixel_write;
	frame_mem_pkg::pixel_t display_pixel, filter_pixel_read, fetch_pixel_read;
	frame_mem_pkg::addr_t mem0_addr, mem1_addr;
	frame_mem_pkg::pixel_t mem0_write, mem1_write, mem0_read, mem1_read;
	logic mem0_wr, mem1_wr;

	// unwritten words of the sparse banks read as a fill pattern
	frame_mem_pkg::pixel_t bank0_mem [frame_mem_pkg::addr_t];
	frame_mem_pkg::pixel_t bank1_mem [frame_mem_pkg::addr_t];
	frame_mem_pkg::pixel_t bank0_stage1 = '0;
	frame_mem_pkg::pixel_t bank0_stage2 = '0;
	frame_mem_pkg::pixel_t bank1_stage1 = '0;
	frame_mem_pkg::pixel_t bank1_stage2 = '0;

	int seed = 32'h1da0_e68a;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	frame_mem_interface UUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Finished with errors");
			$finish;
		end
	end

	function automatic frame_mem_pkg::pixel_t fill_word(input logic bank,
		input frame_mem_pkg::addr_t addr);
		return {bank, addr, ~addr[15:0]};
	endfunction

	// read words appear two edges after the command and writes land on the first
	always @(posedge clk) begin
		if (bank0_mem.exists(mem0_addr))
			bank0_stage1 <= bank0_mem[mem0_addr];
		else
			bank0_stage1 <= fill_word(1'b0, mem0_addr);
		bank0_stage2 <= bank0_stage1;
		if (mem0_wr)
			bank0_mem[mem0_addr] = mem0_write;
		if (bank1_mem.exists(mem1_addr))
			bank1_stage1 <= bank1_mem[mem1_addr];
		else
			bank1_stage1 <= fill_word(1'b1, mem1_addr);
		bank1_stage2 <= bank1_stage1;
		if (mem1_wr)
			bank1_mem[mem1_addr] = mem1_write;
	end

	assign mem0_read = bank0_stage2;
	assign mem1_read = bank1_stage2;

	function automatic int rand_below(input int limit);
		return ($random(seed) & 32'h7fff_ffff) % limit;
	endfunction

	function automatic frame_mem_pkg::pixel_t rand_pixel();
		return frame_mem_pkg::pixel_t'({$random(seed), $random(seed)});
	endfunction

	// bank bit and location of a role after k frame strobes
	function automatic logic [2:0] rotated_slot(input int pos, input int k);
		case ((pos - k) & 3)
			0: return 3'b000;
			1: return 3'b100;
			2: return 3'b101;
			default: return 3'b001;
		endcase
	endfunction

	function automatic frame_mem_pkg::addr_t word_addr(input int x, input int y,
		input logic [1:0] loc);
		int slot_index;
		slot_index = (loc == 2'd3) ? 0 : int'(loc);
		return frame_mem_pkg::addr_t'(x / 2 + y * `ROW_WORDS + slot_index * `SLOT_WORDS);
	endfunction

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d error(s)", tests, name, errors - errors_before);
	endtask

	task automatic set_coords(input int x, input int y);
		capture_x <= frame_mem_pkg::x_t'(x);
		display_x <= frame_mem_pkg::x_t'(x);
		filter_x <= frame_mem_pkg::x_t'(x);
		fetch_x <= frame_mem_pkg::x_t'(x);
		capture_y <= frame_mem_pkg::y_t'(y);
		display_y <= frame_mem_pkg::y_t'(y);
		filter_y <= frame_mem_pkg::y_t'(y);
		fetch_y <= frame_mem_pkg::y_t'(y);
	endtask

	task automatic set_flag(input int pos, input logic level);
		case (pos)
			POS_CAPTURE: capture_flag <= level;
			POS_FETCH: fetch_flag <= level;
			POS_DISPLAY: display_flag <= level;
			default: filter_flag <= level;
		endcase
	endtask

	// one request from a single role checked against its rotated slot
	task automatic probe_role(input int pos, input int k);
		int x;
		int y;
		logic [2:0] slot;
		frame_mem_pkg::addr_t exp_addr;
		logic got_done;
		string tag;
		x = rand_below(`FRAME_WIDTH);
		y = rand_below(`FRAME_HEIGHT);
		slot = rotated_slot(pos, k);
		exp_addr = word_addr(x, y, slot[1:0]);
		tag = $sformatf("role %0d after %0d strobes", pos, k);
		@(posedge clk);
		set_coords(x, y);
		set_flag(pos, 1'b1);
		@(posedge clk);
		set_flag(pos, 1'b0);
		@(negedge clk);
		case (pos)
			POS_CAPTURE: got_done = done_capture;
			POS_FETCH: got_done = done_fetch;
			POS_DISPLAY: got_done = done_display;
			default: got_done = done_filter;
		endcase
		check_value({tag, " done"}, 64'(got_done), 64'd1);
		if (slot[2]) begin
			check_value({tag, " mem1_addr"}, 64'(mem1_addr), 64'(exp_addr));
			check_value({tag, " idle mem0_addr"}, 64'(mem0_addr), 64'd0);
		end else begin
			check_value({tag, " mem0_addr"}, 64'(mem0_addr), 64'(exp_addr));
			check_value({tag, " idle mem1_addr"}, 64'(mem1_addr), 64'd0);
		end
	endtask

	initial begin
		int mark;
		int i;
		int k;
		int pos;
		int cx, cy, dx, dy, fx, fy, hx, hy;
		int xs [3];
		int ys [3];
		logic [2:0] slot;
		frame_mem_pkg::pixel_t cap_data, fil_data, fch_data;
		frame_mem_pkg::pixel_t exp_word, last_display;
		reset = 1'b1;
		frame_flag = 1'b0;
		capture_flag = 1'b0;
		display_flag = 1'b0;
		filter_flag = 1'b0;
		fetch_flag = 1'b0;
		filter_wr = 1'b0;
		fetch_wr = 1'b0;
		capture_pixel = '0;
		filter_pixel_write = '0;
		fetch_pixel_write = '0;
		set_coords(0, 0);
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// capture write on bank 0
		mark = errors;
		@(negedge clk);
		check_value("mem0_wr after reset", 64'(mem0_wr), 64'd0);
		check_value("done_capture after reset", 64'(done_capture), 64'd0);
		check_value("display_pixel after reset", 64'(display_pixel), 64'd0);
		cx = rand_below(`FRAME_WIDTH);
		cy = rand_below(`FRAME_HEIGHT);
		cap_data = rand_pixel();
		slot = rotated_slot(POS_CAPTURE, 0);
		@(posedge clk);
		capture_flag <= 1'b1;
		capture_x <= frame_mem_pkg::x_t'(cx);
		capture_y <= frame_mem_pkg::y_t'(cy);
		capture_pixel <= cap_data;
		@(posedge clk);
		capture_flag <= 1'b0;
		@(negedge clk);
		check_value("capture mem0_addr", 64'(mem0_addr), 64'(word_addr(cx, cy, slot[1:0])));
		check_value("capture mem0_write", 64'(mem0_write), 64'(cap_data));
		check_value("capture mem0_wr", 64'(mem0_wr), 64'd1);
		check_value("capture mem1_wr", 64'(mem1_wr), 64'd0);
		check_value("done_capture", 64'(done_capture), 64'd1);
		report_test("capture write", mark);

		// capture beats filter on bank 0 while display runs on bank 1
		mark = errors;
		cx = rand_below(`FRAME_WIDTH);
		cy = rand_below(`FRAME_HEIGHT);
		fx = rand_below(`FRAME_WIDTH);
		fy = rand_below(`FRAME_HEIGHT);
		dx = rand_below(`FRAME_WIDTH);
		dy = rand_below(`FRAME_HEIGHT);
		fil_data = rand_pixel();
		@(posedge clk);
		capture_flag <= 1'b1;
		capture_x <= frame_mem_pkg::x_t'(cx);
		capture_y <= frame_mem_pkg::y_t'(cy);
		filter_flag <= 1'b1;
		filter_wr <= 1'b1;
		filter_x <= frame_mem_pkg::x_t'(fx);
		filter_y <= frame_mem_pkg::y_t'(fy);
		filter_pixel_write <= fil_data;
		display_flag <= 1'b1;
		display_x <= frame_mem_pkg::x_t'(dx);
		display_y <= frame_mem_pkg::y_t'(dy);
		@(posedge clk);
		display_flag <= 1'b0;
		@(negedge clk);
		slot = rotated_slot(POS_CAPTURE, 0);
		check_value("contended mem0_addr", 64'(mem0_addr), 64'(word_addr(cx, cy, slot[1:0])));
		check_value("contended done_capture", 64'(done_capture), 64'd1);
		check_value("contended done_filter", 64'(done_filter), 64'd0);
		slot = rotated_slot(POS_DISPLAY, 0);
		check_value("parallel mem1_addr", 64'(mem1_addr), 64'(word_addr(dx, dy, slot[1:0])));
		check_value("parallel mem1_wr", 64'(mem1_wr), 64'd0);
		check_value("parallel done_display", 64'(done_display), 64'd1);
		last_display = fill_word(slot[2], word_addr(dx, dy, slot[1:0]));
		@(posedge clk);
		capture_flag <= 1'b0;
		@(negedge clk);
		check_value("held off done_filter", 64'(done_filter), 64'd0);
		@(posedge clk);
		filter_flag <= 1'b0;
		@(negedge clk);
		slot = rotated_slot(POS_FILTER, 0);
		check_value("released done_filter", 64'(done_filter), 64'd1);
		check_value("released done_capture", 64'(done_capture), 64'd0);
		check_value("released mem0_addr", 64'(mem0_addr), 64'(word_addr(fx, fy, slot[1:0])));
		check_value("released mem0_write", 64'(mem0_write), 64'(fil_data));
		check_value("released mem0_wr", 64'(mem0_wr), 64'd1);
		report_test("priority", mark);

		// three display reads in a row
		mark = errors;
		slot = rotated_slot(POS_DISPLAY, 0);
		for (i = 0; i < 3; i++) begin
			xs[i] = rand_below(`FRAME_WIDTH);
			ys[i] = rand_below(`FRAME_HEIGHT);
		end
		exp_word = last_display;
		for (i = 0; i < 8; i++) begin
			@(posedge clk);
			if (i < 3) begin
				display_flag <= 1'b1;
				display_x <= frame_mem_pkg::x_t'(xs[i]);
				display_y <= frame_mem_pkg::y_t'(ys[i]);
			end else begin
				display_flag <= 1'b0;
			end
			@(negedge clk);
			// the read driven at edge i - 4 has just landed
			if (i >= 4 && i < 7)
				exp_word = fill_word(slot[2], word_addr(xs[i - 4], ys[i - 4], slot[1:0]));
			check_value($sformatf("display_pixel at edge %0d", i), 64'(display_pixel),
				64'(exp_word));
		end
		report_test("display burst", mark);

		// write then read back on the filter and fetch slots
		mark = errors;
		fx = rand_below(`FRAME_WIDTH);
		fy = rand_below(`FRAME_HEIGHT);
		hx = rand_below(`FRAME_WIDTH);
		hy = rand_below(`FRAME_HEIGHT);
		fil_data = rand_pixel();
		fch_data = rand_pixel();
		@(posedge clk);
		filter_flag <= 1'b1;
		filter_wr <= 1'b1;
		filter_x <= frame_mem_pkg::x_t'(fx);
		filter_y <= frame_mem_pkg::y_t'(fy);
		filter_pixel_write <= fil_data;
		fetch_flag <= 1'b1;
		fetch_wr <= 1'b1;
		fetch_x <= frame_mem_pkg::x_t'(hx);
		fetch_y <= frame_mem_pkg::y_t'(hy);
		fetch_pixel_write <= fch_data;
		@(posedge clk);
		filter_wr <= 1'b0;
		fetch_wr <= 1'b0;
		@(negedge clk);
		slot = rotated_slot(POS_FILTER, 0);
		check_value("write done_filter", 64'(done_filter), 64'd1);
		check_value("write mem0_addr", 64'(mem0_addr), 64'(word_addr(fx, fy, slot[1:0])));
		check_value("write mem0_write", 64'(mem0_write), 64'(fil_data));
		check_value("write mem0_wr", 64'(mem0_wr), 64'd1);
		slot = rotated_slot(POS_FETCH, 0);
		check_value("write done_fetch", 64'(done_fetch), 64'd1);
		check_value("write mem1_addr", 64'(mem1_addr), 64'(word_addr(hx, hy, slot[1:0])));
		check_value("write mem1_write", 64'(mem1_write), 64'(fch_data));
		check_value("write mem1_wr", 64'(mem1_wr), 64'd1);
		@(posedge clk);
		filter_flag <= 1'b0;
		fetch_flag <= 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		// write grants return no word and no read has come back to these clients yet
		check_value("filter_pixel_read over the write", 64'(filter_pixel_read), 64'd0);
		check_value("fetch_pixel_read over the write", 64'(fetch_pixel_read), 64'd0);
		@(posedge clk);
		@(negedge clk);
		check_value("filter_pixel_read", 64'(filter_pixel_read), 64'(fil_data));
		check_value("fetch_pixel_read", 64'(fetch_pixel_read), 64'(fch_data));
		report_test("write and read back", mark);

		// every role across four frame strobes
		mark = errors;
		for (k = 0; k <= 4; k++) begin
			if (k > 0) begin
				@(posedge clk);
				frame_flag <= 1'b1;
				@(posedge clk);
				frame_flag <= 1'b0;
			end
			for (pos = 0; pos < 4; pos++)
				probe_role(pos, k);
		end
		report_test("slot rotation", mark);

		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- list.f
+incdir+common
common/frame_mem_pkg.sv
verilog/frame_rotator.sv
arbiter/pixel_address.sv
arbiter/bank_arbiter.sv
verilog/read_return.sv
verilog/frame_mem_interface.sv
tests/tb_frame_mem.sv

//--- run_sim.sh
#!/bin/sh
# build and run the frame buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_frame_mem -f list.f -o tb_frame_mem
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_frame_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
